// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
LINTFLAGS := --lint-only --timing
TOP       := fmtcast_tb
RTL_TOP   := fmtcast_top
FILELIST  := project.f
OBJ_DIR   := obj_dir
PASS_MSG  := Regression passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== project.f ====
source/fmtcast_pkg.sv
source/fmtcast_decoder.sv
source/fp16_to_fp8_lane.sv
source/fp8_to_fp16_lane.sv
source/fmtcast_execute.sv
source/fmtcast_result.sv
source/fmtcast_top.sv
test/fmtcast_tb.sv

// ==== source/fmtcast_decoder.sv ====
// ======================================================================
// Format cast decoder
// Registers an incoming command and turns reserved opcodes into bypass
// ======================================================================

`timescale 1ns/1ps

module fmtcast_decoder #(
  parameter int unsigned DATA_W = fmtcast_pkg::DEF_DATA_W
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  clear_i,
  input  logic                  cmd_valid_i,
  input  fmtcast_pkg::cast_op_e cmd_op_i,
  input  logic [DATA_W-1:0]     cmd_data_i,
  output fmtcast_pkg::dec_req_t dec_o
);
  import fmtcast_pkg::*;

  logic                  valid_q;
  logic                  illegal_q;
  cast_op_e              op_q;
  logic [MAX_DATA_W-1:0] data_q;
  cast_op_e              op_d;
  logic                  illegal_d;
  logic [MAX_DATA_W-1:0] data_d;

  // Reserved codes run as bypass so later stages only see legal operations
  always_comb begin
    op_d      = cmd_op_i;
    illegal_d = 1'b0;
    case (cmd_op_i)
      OP_RSVD: begin
        op_d      = OP_BYPASS;
        illegal_d = 1'b1;
      end
      default: op_d = cmd_op_i;
    endcase
    data_d                = '0;  // Zero extension up to the struct width
    data_d[DATA_W-1:0]    = cmd_data_i;
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q   <= 1'b0;
      illegal_q <= 1'b0;
    end else if (clear_i) begin
      valid_q   <= 1'b0;  // Flush drops the command in this stage
      illegal_q <= 1'b0;
    end else begin
      valid_q <= cmd_valid_i;
      if (cmd_valid_i) illegal_q <= illegal_d;
    end
  end

  // Operation and payload only follow accepted commands
  always_ff @(posedge clk_i) begin
    if (cmd_valid_i) begin
      op_q   <= op_d;
      data_q <= data_d;
    end
  end

  always_comb begin
    dec_o.valid   = valid_q;
    dec_o.op      = op_q;
    dec_o.illegal = illegal_q;
    dec_o.data    = data_q;
  end

endmodule : fmtcast_decoder

// ==== source/fmtcast_execute.sv ====
// ======================================================================
// Format cast execute stage
// Per-lane narrowing and widening units over the decoded data word
// ======================================================================

`timescale 1ns/1ps

module fmtcast_execute #(
  parameter int unsigned DATA_W = fmtcast_pkg::DEF_DATA_W
) (
  input  fmtcast_pkg::dec_req_t dec_i,
  output logic [DATA_W-1:0]     narrow_lanes_o,
  output logic [DATA_W-1:0]     wide_word_o
);
  import fmtcast_pkg::*;

  localparam int unsigned NUM_LANES = DATA_W / FP16_W;

  logic [NUM_LANES-1:0][FP8_W-1:0]  narrow_byte;
  logic [NUM_LANES-1:0][FP16_W-1:0] wide_lane;

  for (genvar i = 0; i < NUM_LANES; i++) begin : gen_lane

    // Narrowing reads the full FP16 lane i
    fp16_to_fp8_lane u_narrow (
      .fp16_i ( dec_i.data[i*FP16_W +: FP16_W] ),
      .fp8_o  ( narrow_byte[i]                  )
    );

    // Widening reads byte i, so only the low half of the word is consumed
    fp8_to_fp16_lane u_widen (
      .fp8_i  ( dec_i.data[i*FP8_W +: FP8_W] ),
      .fp16_o ( wide_lane[i]                  )
    );

    // Narrowed byte sits in the low byte of its own lane
    assign narrow_lanes_o[i*FP16_W +: FP16_W] = {{(FP16_W-FP8_W){1'b0}}, narrow_byte[i]};
    assign wide_word_o[i*FP16_W +: FP16_W]    = wide_lane[i];

  end : gen_lane

endmodule : fmtcast_execute

// ==== source/fmtcast_pkg.sv ====
// ======================================================================
// Format cast engine package
// Opcodes, FP16 and E5M2 field widths and the decoded command struct
// ======================================================================

package fmtcast_pkg;

  // Lane widths of the two floating-point formats
  localparam int unsigned FP16_W     = 16;
  localparam int unsigned FP8_W      = 8;
  localparam int unsigned FP16_MAN_W = 10;
  localparam int unsigned FP8_MAN_W  = 2;
  localparam int unsigned EXP_W      = 5;  // Same exponent field in FP16 and E5M2

  // Word widths seen by the pipeline
  localparam int unsigned DEF_DATA_W = 64;
  localparam int unsigned MAX_DATA_W = 128;  // Widest word the decoded struct can carry

  // Mantissa pattern of the quiet NaN produced by narrowing
  localparam logic [FP8_MAN_W-1:0] FP8_QNAN_MAN = 2'b10;

  // Command opcodes
  typedef enum logic [1:0] {
    OP_BYPASS = 2'd0,
    OP_NARROW = 2'd1,
    OP_WIDEN  = 2'd2,
    OP_RSVD   = 2'd3
  } cast_op_e;

  // Field view of one FP16 value
  typedef struct packed {
    logic                  sign;
    logic [EXP_W-1:0]      exp;
    logic [FP16_MAN_W-1:0] man;
  } fp16_t;

  // Field view of one E5M2 value
  typedef struct packed {
    logic                 sign;
    logic [EXP_W-1:0]     exp;
    logic [FP8_MAN_W-1:0] man;
  } fp8_t;

  // Decoded command handed from the decoder to execute and result
  typedef struct packed {
    logic                  valid;
    cast_op_e              op;       // Never OP_RSVD after decode
    logic                  illegal;  // Opcode was reserved
    logic [MAX_DATA_W-1:0] data;     // Only the low DATA_W bits are meaningful
  } dec_req_t;

endpackage : fmtcast_pkg

// ==== source/fmtcast_result.sv ====
// ======================================================================
// Format cast result stage
// Packs narrowed bytes, selects by operation and registers the output
// ======================================================================

`timescale 1ns/1ps

module fmtcast_result #(
  parameter int unsigned DATA_W = fmtcast_pkg::DEF_DATA_W
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  clear_i,
  input  fmtcast_pkg::dec_req_t dec_i,
  input  logic [DATA_W-1:0]     narrow_lanes_i,
  input  logic [DATA_W-1:0]     wide_word_i,
  output logic                  res_valid_o,
  output logic [DATA_W-1:0]     res_data_o,
  output logic                  res_err_o
);
  import fmtcast_pkg::*;

  localparam int unsigned NUM_LANES = DATA_W / FP16_W;

  logic [DATA_W-1:0] packed_word;
  logic [DATA_W-1:0] sel_word;
  logic              valid_q;
  logic              err_q;
  logic [DATA_W-1:0] data_q;

  // Bytes are gathered contiguously from the bottom, upper half stays zero
  always_comb begin
    packed_word = '0;
    for (int i = 0; i < NUM_LANES; i++) begin
      packed_word[i*FP8_W +: FP8_W] = narrow_lanes_i[i*FP16_W +: FP8_W];
    end
  end

  always_comb begin
    case (dec_i.op)
      OP_NARROW: sel_word = packed_word;
      OP_WIDEN:  sel_word = wide_word_i;
      default:   sel_word = dec_i.data[DATA_W-1:0];  // Bypass and remapped reserved codes
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
      err_q   <= 1'b0;
      data_q  <= '0;
    end else begin
      if (clear_i) begin
        valid_q <= 1'b0;
        err_q   <= 1'b0;
      end else begin
        valid_q <= dec_i.valid;
        err_q   <= dec_i.valid & dec_i.illegal;  // Flag lives for its own result only
      end
      if (dec_i.valid) data_q <= sel_word;
    end
  end

  assign res_valid_o = valid_q;
  assign res_data_o  = data_q;
  assign res_err_o   = err_q;

endmodule : fmtcast_result

// ==== source/fmtcast_top.sv ====
// ======================================================================
// Format cast engine top level
// Decode, execute and result stages with a two cycle command latency
// ======================================================================

`timescale 1ns/1ps

module fmtcast_top #(
  parameter int unsigned DATA_W = fmtcast_pkg::DEF_DATA_W
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  clear_i,
  input  logic                  cmd_valid_i,
  input  fmtcast_pkg::cast_op_e cmd_op_i,
  input  logic [DATA_W-1:0]     cmd_data_i,
  output logic                  res_valid_o,
  output logic [DATA_W-1:0]     res_data_o,
  output logic                  res_err_o
);
  import fmtcast_pkg::*;

  dec_req_t          dec_q;         // Registered command after decode
  logic [DATA_W-1:0] narrow_lanes;
  logic [DATA_W-1:0] wide_word;

  fmtcast_decoder #(
    .DATA_W ( DATA_W )
  ) u_decoder (
    .clk_i       ( clk_i       ),
    .rst_n_i     ( rst_n_i     ),
    .clear_i     ( clear_i     ),
    .cmd_valid_i ( cmd_valid_i ),
    .cmd_op_i    ( cmd_op_i    ),
    .cmd_data_i  ( cmd_data_i  ),
    .dec_o       ( dec_q       )
  );

  fmtcast_execute #(
    .DATA_W ( DATA_W )
  ) u_execute (
    .dec_i          ( dec_q        ),
    .narrow_lanes_o ( narrow_lanes ),
    .wide_word_o    ( wide_word    )
  );

  fmtcast_result #(
    .DATA_W ( DATA_W )
  ) u_result (
    .clk_i          ( clk_i        ),
    .rst_n_i        ( rst_n_i      ),
    .clear_i        ( clear_i      ),
    .dec_i          ( dec_q        ),
    .narrow_lanes_i ( narrow_lanes ),
    .wide_word_i    ( wide_word    ),
    .res_valid_o    ( res_valid_o  ),
    .res_data_o     ( res_data_o   ),
    .res_err_o      ( res_err_o    )
  );

endmodule : fmtcast_top

// ==== source/fp16_to_fp8_lane.sv ====
// ======================================================================
// FP16 to E5M2 narrowing lane
// Round to nearest even with overflow to infinity and quiet NaN output
// ======================================================================

`timescale 1ns/1ps

module fp16_to_fp8_lane (
  input  logic [fmtcast_pkg::FP16_W-1:0] fp16_i,
  output logic [fmtcast_pkg::FP8_W-1:0]  fp8_o
);
  import fmtcast_pkg::*;

  // Mantissa bits that fall away in the narrower format
  localparam int unsigned DROP_W = FP16_MAN_W - FP8_MAN_W;
  localparam int unsigned MAG_W  = EXP_W + FP8_MAN_W;

  fp16_t                src;
  fp8_t                 dst;
  logic [FP8_MAN_W-1:0] man_keep;
  logic                 guard_bit;
  logic                 sticky_bit;
  logic                 round_up;
  logic                 is_nan;
  logic                 is_inf;
  logic [MAG_W-1:0]     mag_trunc;
  logic [MAG_W-1:0]     mag_rnd;
  logic                 mag_ovf;

  assign src = fp16_i;

  // The exponent field is shared, so only the mantissa needs rounding
  assign man_keep   = src.man[FP16_MAN_W-1 -: FP8_MAN_W];
  assign guard_bit  = src.man[DROP_W-1];   // First bit below the kept LSB
  assign sticky_bit = |src.man[DROP_W-2:0];

  // Ties go to the value whose kept LSB is zero
  assign round_up = guard_bit & (sticky_bit | man_keep[0]);

  assign is_nan = (&src.exp) & (|src.man);
  assign is_inf = (&src.exp) & ~(|src.man);

  // Treating exponent and mantissa as one magnitude lets a mantissa
  // carry roll straight into the exponent, subnormals included
  assign mag_trunc = {src.exp, man_keep};
  assign mag_rnd   = mag_trunc + {{(MAG_W-1){1'b0}}, round_up};

  // A rounded exponent of all ones means the value left the finite range
  assign mag_ovf = &mag_rnd[MAG_W-1:FP8_MAN_W];

  always_comb begin
    dst.sign = src.sign;
    dst.exp  = mag_rnd[MAG_W-1:FP8_MAN_W];
    dst.man  = mag_rnd[FP8_MAN_W-1:0];
    if (is_nan) begin
      dst.exp = '1;
      dst.man = FP8_QNAN_MAN;  // Payload is not kept, NaN comes out quiet
    end else if (is_inf || mag_ovf) begin
      dst.exp = '1;
      dst.man = '0;
    end
  end

  assign fp8_o = dst;

endmodule : fp16_to_fp8_lane

// ==== source/fp8_to_fp16_lane.sv ====
// ======================================================================
// E5M2 to FP16 widening lane
// Exact conversion by extending the mantissa with zeros
// ======================================================================

`timescale 1ns/1ps

module fp8_to_fp16_lane (
  input  logic [fmtcast_pkg::FP8_W-1:0]  fp8_i,
  output logic [fmtcast_pkg::FP16_W-1:0] fp16_o
);
  import fmtcast_pkg::*;

  localparam int unsigned PAD_W = FP16_MAN_W - FP8_MAN_W;

  fp8_t  src;
  fp16_t dst;

  assign src = fp8_i;

  // Both formats use the same biased exponent, so sign and exponent pass
  // as they are and subnormals, infinities and NaN payloads stay exact
  always_comb begin
    dst.sign = src.sign;
    dst.exp  = src.exp;
    dst.man  = {src.man, {PAD_W{1'b0}}};  // Kept bits land at the mantissa top
  end

  assign fp16_o = dst;

endmodule : fp8_to_fp16_lane

// ==== test/fmtcast_tb.sv ====
// ======================================================================
// Format cast engine testbench
// Random and directed commands, checked by concurrent assertions
// ======================================================================

`timescale 1ns/1ps

module fmtcast_tb;
  import fmtcast_pkg::*;

  localparam int unsigned DATA_W     = 64;
  localparam int unsigned LANES      = DATA_W / 16;
  localparam int unsigned TOTAL_CMDS = 150;  // Sum of the commands of all tests below

  typedef struct packed {
    logic [31:0]       issue;  // Cycle at which the command was sampled
    logic              err;
    logic [DATA_W-1:0] data;
  } exp_t;

  logic              clk_i;
  logic              rst_n_i;
  logic              clear_i;
  logic              cmd_valid_i;
  cast_op_e          cmd_op_i;
  logic [DATA_W-1:0] cmd_data_i;
  logic              res_valid_o;
  logic [DATA_W-1:0] res_data_o;
  logic              res_err_o;

  // Expected response that travels with the command being driven
  logic [DATA_W-1:0] cmd_exp_data;
  logic              cmd_exp_err;

  exp_t              exp_q[$];
  logic              exp_valid;
  logic [DATA_W-1:0] exp_data;
  logic              exp_err;
  logic              seen_cmd;
  logic [31:0]       cyc;
  logic [31:0]       seed;
  int                fail_cnt = 0;
  int                result_cnt = 0;
  int                cmd_cnt = 0;
  int                tests_run = 0;
  int                tests_failed = 0;
  int                test_fail_base = 0;
  int                test_cmd_base = 0;

  // Directed FP16 inputs and their E5M2 results worked out by hand
  logic [15:0] dir_in [12] = '{16'h3C00, 16'h3C80, 16'h3D80, 16'h3FC0,
                               16'h7BFF, 16'hFC00, 16'h7E01, 16'h7C01,
                               16'h8000, 16'h0180, 16'h03FF, 16'h0001};
  logic [7:0]  dir_out [12] = '{8'h3C, 8'h3C, 8'h3E, 8'h40,
                                8'h7C, 8'hFC, 8'h7E, 8'h7E,
                                8'h80, 8'h02, 8'h04, 8'h00};

  fmtcast_top #(
    .DATA_W ( DATA_W )
  ) dut0 (
    .clk_i       ( clk_i       ),
    .rst_n_i     ( rst_n_i     ),
    .clear_i     ( clear_i     ),
    .cmd_valid_i ( cmd_valid_i ),
    .cmd_op_i    ( cmd_op_i    ),
    .cmd_data_i  ( cmd_data_i  ),
    .res_valid_o ( res_valid_o ),
    .res_data_o  ( res_data_o  ),
    .res_err_o   ( res_err_o   )
  );

  always #5 clk_i = ~clk_i;

  function automatic logic [31:0] lcg_next();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic logic [DATA_W-1:0] rand_word();
    logic [DATA_W-1:0] w;
    for (int i = 0; i < DATA_W / 32; i++) begin
      w[i*32 +: 32] = lcg_next();
    end
    return w;
  endfunction

  // Keep the top 2 of 10 mantissa bits and round the remainder half to even
  function automatic logic [7:0] narrow_ref(input logic [15:0] h);
    logic [4:0] e;
    logic [9:0] m;
    logic [2:0] q;     // One spare bit catches the mantissa carry
    logic [7:0] rest;
    e = h[14:10];
    m = h[9:0];
    if (e == 5'h1F) begin
      if (m != 10'd0) return {h[15], 5'h1F, 2'b10};
      return {h[15], 5'h1F, 2'b00};
    end
    q    = {1'b0, m[9:8]};
    rest = m[7:0];
    if (rest > 8'h80 || (rest == 8'h80 && q[0])) q = q + 3'd1;
    if (q[2]) begin
      q = 3'd0;
      e = e + 5'd1;  // A subnormal that rounds up becomes the smallest normal
    end
    if (e == 5'h1F) return {h[15], 5'h1F, 2'b00};
    return {h[15], e, q[1:0]};
  endfunction

  function automatic logic [DATA_W-1:0] expect_word(input cast_op_e op,
                                                    input logic [DATA_W-1:0] d);
    logic [DATA_W-1:0] w;
    w = '0;
    case (op)
      OP_NARROW: begin
        for (int i = 0; i < LANES; i++) w[i*8 +: 8] = narrow_ref(d[i*16 +: 16]);
      end
      OP_WIDEN: begin
        for (int i = 0; i < LANES; i++) w[i*16 +: 16] = {d[i*8 +: 8], 8'h00};
      end
      default: w = d;
    endcase
    return w;
  endfunction

  task automatic drive_cmd(input cast_op_e op, input logic [DATA_W-1:0] d,
                           input logic [DATA_W-1:0] exp_d, input logic exp_e);
    @(negedge clk_i);
    cmd_valid_i  = 1'b1;
    clear_i      = 1'b0;
    cmd_op_i     = op;
    cmd_data_i   = d;
    cmd_exp_data = exp_d;
    cmd_exp_err  = exp_e;
    cmd_cnt++;
  endtask

  task automatic issue_cmd(input cast_op_e op, input logic [DATA_W-1:0] d);
    drive_cmd(op, d, expect_word(op, d), op == OP_RSVD);
  endtask

  task automatic go_idle();
    @(negedge clk_i);
    cmd_valid_i = 1'b0;
    clear_i     = 1'b0;
  endtask

  // Returns once every expected result has been compared
  task automatic drain();
    go_idle();
    while (exp_q.size() != 0 || exp_valid) @(negedge clk_i);
  endtask

  task automatic finish_test(input string name);
    int errs;
    drain();
    errs = fail_cnt - test_fail_base;
    tests_run++;
    if (errs != 0) tests_failed++;
    $display("Test %-10s %0d commands, %0d errors", name, cmd_cnt - test_cmd_base, errs);
    test_fail_base = fail_cnt;
    test_cmd_base  = cmd_cnt;
  endtask

  // Expected results queue, popped one edge before the outputs are compared
  always @(posedge clk_i) begin
    exp_t e;
    if (!rst_n_i) begin
      exp_q.delete();
      exp_valid <= 1'b0;
      seen_cmd  <= 1'b0;
      cyc       <= '0;
    end else begin
      if (clear_i) begin
        // Flush kills the command in decode and the one arriving now
        while (exp_q.size() > 0 && exp_q[exp_q.size()-1].issue + 1 >= cyc) begin
          void'(exp_q.pop_back());
        end
      end else if (cmd_valid_i) begin
        e.issue = cyc;
        e.err   = cmd_exp_err;
        e.data  = cmd_exp_data;
        exp_q.push_back(e);
        seen_cmd <= 1'b1;
      end
      if (exp_q.size() > 0 && exp_q[0].issue + 1 == cyc) begin
        e = exp_q.pop_front();
        exp_valid <= 1'b1;
        exp_data  <= e.data;
        exp_err   <= e.err;
        result_cnt++;
      end else begin
        exp_valid <= 1'b0;
      end
      cyc <= cyc + 1;
    end
  end

  idle_check: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      !seen_cmd |-> (res_data_o == '0))
    else begin
      fail_cnt++;
      $display("Fail res_data_o got %h expected 0 before any command", $sampled(res_data_o));
    end

  valid_check: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      res_valid_o == exp_valid)
    else begin
      fail_cnt++;
      $display("Fail res_valid_o got %h expected %h", $sampled(res_valid_o),
               $sampled(exp_valid));
    end

  data_check: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      exp_valid |-> (res_data_o == exp_data))
    else begin
      fail_cnt++;
      $display("Fail res_data_o got %h expected %h", $sampled(res_data_o),
               $sampled(exp_data));
    end

  err_check: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      res_err_o == (exp_valid & exp_err))
    else begin
      fail_cnt++;
      $display("Fail res_err_o got %h expected %h", $sampled(res_err_o),
               $sampled(exp_valid & exp_err));
    end

  // One cycle per command plus margin for reset, idle gaps and draining
  initial begin
    #(TOTAL_CMDS * 10 + 2000);
    $display("Watchdog expired before all tests finished");
    $display("Regression failed");
    $finish;
  end

  initial begin
    logic [DATA_W-1:0] w;
    logic [DATA_W-1:0] wide;
    logic [DATA_W-1:0] ex;
    logic [31:0]       r;
    logic [7:0]        b;
    clk_i        = 1'b0;
    rst_n_i      = 1'b0;
    clear_i      = 1'b0;
    cmd_valid_i  = 1'b0;
    cmd_op_i     = OP_BYPASS;
    cmd_data_i   = '0;
    cmd_exp_data = '0;
    cmd_exp_err  = 1'b0;
    seed         = 32'h5bf9_9bda;
    repeat (8) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;

    repeat (16) go_idle();
    finish_test("reset");

    for (int n = 0; n < 32; n++) issue_cmd(OP_BYPASS, rand_word());
    finish_test("bypass");

    for (int k = 0; k < 3; k++) begin
      w  = '0;
      ex = '0;
      for (int i = 0; i < LANES; i++) begin
        w[i*16 +: 16] = dir_in[k*LANES + i];
        ex[i*8 +: 8]  = dir_out[k*LANES + i];
      end
      drive_cmd(OP_NARROW, w, ex, 1'b0);
    end
    for (int n = 0; n < 32; n++) issue_cmd(OP_NARROW, rand_word());
    finish_test("narrow");

    for (int n = 0; n < 32; n++) issue_cmd(OP_WIDEN, rand_word());
    finish_test("widen");

    // Widened bytes narrowed again must come back unchanged
    for (int n = 0; n < 16; n++) begin
      w = rand_word();
      w[DATA_W-1:DATA_W/2] = '0;
      wide = '0;
      for (int i = 0; i < LANES; i++) begin
        b = w[i*8 +: 8];
        if (b[6:2] == 5'h1F && b[1:0] != 2'b00) b[1:0] = 2'b10;  // Only quiet NaN survives
        w[i*8 +: 8]     = b;
        wide[i*16 +: 16] = {b, 8'h00};
      end
      drive_cmd(OP_NARROW, wide, w, 1'b0);
    end
    finish_test("roundtrip");

    for (int n = 0; n < 8; n++) begin
      if (n[0]) issue_cmd(OP_BYPASS, rand_word());
      else issue_cmd(OP_RSVD, rand_word());
    end
    finish_test("illegal");

    for (int n = 0; n < 24; n++) begin
      r = lcg_next();
      issue_cmd(cast_op_e'(r[31:30]), rand_word());
    end
    finish_test("pipeline");

    issue_cmd(OP_NARROW, rand_word());
    issue_cmd(OP_WIDEN, rand_word());
    clear_i = 1'b1;  // Same edge as the second command
    issue_cmd(OP_BYPASS, rand_word());
    finish_test("clear");

    $display("Summary %0d tests, %0d failed, %0d results checked, %0d check failures",
             tests_run, tests_failed, result_cnt, fail_cnt);
    if (fail_cnt == 0 && tests_failed == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule : fmtcast_tb
